// ==== Bender.yml ====
package:
  name: spram

export_include_dirs:
  - .

sources:
  - files:
      - spram_cfg_pkg.sv
      - spram_bus_pkg.sv
      - spram_core.sv
      - spram_out_pipe.sv
      - spram_top.sv

  - target: test
    files:
      - spram_asserts.sv
      - spram_tb.sv

// ==== spram_asserts.sv ====
// Concurrent checks on the RAM top level, bound into every spram_top.
// Failures are counted so that the testbench can see them at the end.
`default_nettype none
`timescale 1ns/1ps

`include "spram_defines.svh"

module spram_asserts #(
    parameter int read_latency = `SPRAM_READ_LATENCY
) (
    input logic                      clka,
    input logic                      rsta,
    input spram_bus_pkg::spram_req_t req,
    input logic                      regcea,
    input spram_cfg_pkg::word_t      douta
);
    import spram_cfg_pkg::*;
    import spram_bus_pkg::*;

    int failures = 0;

    a_reset_value: assert property (@(posedge clka) rsta |-> douta == `SPRAM_RESET_VALUE)
        else begin
            failures++;
            $error("douta differs from the reset value while rsta is high");
        end

    // Final stage frozen while regcea is low
    a_regcea_hold: assert property (@(posedge clka) disable iff (rsta)
        (read_latency > 1 && !regcea) |=> $stable(douta))
        else begin
            failures++;
            $error("douta changed across an edge with regcea low");
        end

    a_req_known: assert property (@(posedge clka) req.en |-> !$isunknown(req))
        else begin
            failures++;
            $error("Request has unknown bits during an access");
        end

endmodule

bind spram_top spram_asserts #(
    .read_latency (read_latency)
) asrt0 (
    .clka   (clka),
    .rsta   (rsta),
    .req    (req),
    .regcea (regcea),
    .douta  (douta)
);

`default_nettype wire

// ==== spram_bus_pkg.sv ====
// Port-A request bundle of the single-port RAM.
// One value per clka cycle, en high marks an access.
`default_nettype none

package spram_bus_pkg;
    import spram_cfg_pkg::*;

    // A nonzero we turns the access into a write of the enabled lanes
    typedef struct packed {
        logic  en;     // Access strobe
        be_t   we;     // Byte-lane write enables
        addr_t addr;   // Word address
        word_t din;    // Write data
    } spram_req_t;

endpackage

`default_nettype wire

// ==== spram_cfg_pkg.sv ====
// Storage-side types of the single-port RAM.
// Shared by the core, the output pipe and the testbench model.
`default_nettype none

`include "spram_defines.svh"

package spram_cfg_pkg;

    // Derived sizes
    localparam int num_bytes = `SPRAM_DATA_WIDTH / `SPRAM_BYTE_WIDTH;
    localparam int depth     = 1 << `SPRAM_ADDR_WIDTH;

    typedef logic [`SPRAM_ADDR_WIDTH-1:0] addr_t;   // Word address
    typedef logic [`SPRAM_DATA_WIDTH-1:0] word_t;   // One data word
    typedef logic [num_bytes-1:0]         be_t;     // One bit per byte lane

    // What the first output register shows on a write cycle
    typedef enum logic [1:0] {
        wm_read_first  = 2'd0,   // Old contents
        wm_write_first = 2'd1,   // Old contents merged with the new lanes
        wm_no_change   = 2'd2    // Output held
    } write_mode_e;

endpackage

`default_nettype wire

// ==== spram_core.sv ====
// Storage half of the single-port RAM.
// Holds the array, applies byte-lane writes and loads the first output
// register according to the write mode. The array has no reset.
`default_nettype none
`timescale 1ns/1ps

`include "spram_defines.svh"

module spram_core #(
    parameter spram_cfg_pkg::write_mode_e write_mode = spram_cfg_pkg::wm_write_first
) (
    input  logic                      clka,
    input  logic                      rsta,     // Async, clears stage1 only
    input  spram_bus_pkg::spram_req_t req,
    output spram_cfg_pkg::word_t      stage1    // First output register
);
    import spram_cfg_pkg::*;
    import spram_bus_pkg::*;

    word_t mem [depth];

    word_t old_word;      // Contents at req.addr before this edge
    word_t merged_word;   // Old contents with the enabled lanes replaced
    logic  is_write;

    // Replace each lane whose enable is set
    function automatic word_t merge_lanes(word_t base, word_t data, be_t lanes);
        word_t result;
        result = base;
        for (int b = 0; b < num_bytes; b++) begin
            if (lanes[b]) begin
                result[b*`SPRAM_BYTE_WIDTH +: `SPRAM_BYTE_WIDTH] =
                    data[b*`SPRAM_BYTE_WIDTH +: `SPRAM_BYTE_WIDTH];
            end
        end
        return result;
    endfunction

    // Unwritten locations read back as zero in simulation
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    assign old_word    = mem[req.addr];
    assign merged_word = merge_lanes(old_word, req.din, req.we);
    assign is_write    = |req.we;

    // Byte-lane write, same edge as the access
    always @(posedge clka) begin
        if (req.en) begin
            for (int b = 0; b < num_bytes; b++) begin
                if (req.we[b]) begin
                    mem[req.addr][b*`SPRAM_BYTE_WIDTH +: `SPRAM_BYTE_WIDTH] <=
                        req.din[b*`SPRAM_BYTE_WIDTH +: `SPRAM_BYTE_WIDTH];
                end
            end
        end
    end

    // First output register, holds while en is low
    always_ff @(posedge clka or posedge rsta) begin
        if (rsta) begin
            stage1 <= `SPRAM_RESET_VALUE;
        end else if (req.en) begin
            case (write_mode)
                wm_read_first: begin
                    stage1 <= old_word;
                end
                wm_write_first: begin
                    stage1 <= merged_word;    // Equals old_word on a plain read
                end
                wm_no_change: begin
                    if (!is_write) begin
                        stage1 <= old_word;   // Writes leave the output alone
                    end
                end
                default: begin
                    stage1 <= old_word;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== spram_defines.svh ====
// Build-time sizes and reset value for the single-port RAM.
// Include wherever a width, the default latency or the reset word is needed.

`ifndef SPRAM_DEFINES_SVH
`define SPRAM_DEFINES_SVH

// Word address bits, depth is always a power of two
`define SPRAM_ADDR_WIDTH 6

// Data word bits, a whole number of byte lanes
`define SPRAM_DATA_WIDTH 32

// Bits per write lane
`define SPRAM_BYTE_WIDTH 8

// Default total read latency in clka edges, legal range 1 to 5
`define SPRAM_READ_LATENCY 3

// Value that douta and every output stage take while rsta is high
`define SPRAM_RESET_VALUE {`SPRAM_DATA_WIDTH{1'b0}}

`endif

// ==== spram_out_pipe.sv ====
// Output registers 2 to N of the single-port RAM.
// Middle stages advance on every edge, the final stage loads only while
// regcea is high. Latency 1 has no extra stage at all.
`default_nettype none
`timescale 1ns/1ps

`include "spram_defines.svh"

module spram_out_pipe #(
    parameter int read_latency = `SPRAM_READ_LATENCY
) (
    input  logic                 clka,
    input  logic                 rsta,
    input  spram_cfg_pkg::word_t stage1,
    input  logic                 regcea,   // Final stage enable
    output spram_cfg_pkg::word_t douta
);
    import spram_cfg_pkg::*;

    if (read_latency < 1 || read_latency > 5) begin : gen_bad_latency
        $error("spram_out_pipe: read_latency %0d outside 1 to 5", read_latency);
    end

    if (read_latency == 1) begin : gen_direct
        assign douta = stage1;   // stage1 is the only register
    end else begin : gen_pipe
        for (genvar i = 0; i < read_latency - 1; i++) begin : gen_stage
            word_t d;
            word_t q;
            logic  load;

            if (i == 0) begin : gen_first
                assign d = stage1;
            end else begin : gen_next
                assign d = gen_stage[i-1].q;
            end

            // Only the last stage listens to regcea
            assign load = (i == read_latency - 2) ? regcea : 1'b1;

            always_ff @(posedge clka or posedge rsta) begin
                if (rsta) begin
                    q <= `SPRAM_RESET_VALUE;
                end else if (load) begin
                    q <= d;
                end
            end
        end

        assign douta = gen_stage[read_latency-2].q;
    end

endmodule

`default_nettype wire

// ==== spram_tb.sv ====
// Directed testbench for the single-port RAM top level.
// A word-array model predicts douta for every access. Override tb_write_mode
// or tb_read_latency to run the other builds.
`default_nettype none
`timescale 1ns/1ps

`include "spram_defines.svh"

module spram_tb #(
    parameter spram_cfg_pkg::write_mode_e tb_write_mode   = spram_cfg_pkg::wm_write_first,
    parameter int                         tb_read_latency = `SPRAM_READ_LATENCY
);
    import spram_cfg_pkg::*;
    import spram_bus_pkg::*;

    localparam int clk_period   = 40;
    localparam int num_tests    = 6;
    localparam int cycle_budget = 200;   // Cycles per test, well above the longest
    localparam int num_words    = 8;

    logic       clka;
    logic       rsta;
    spram_req_t req;
    logic       regcea;
    word_t      douta;

    word_t model_mem [depth];
    word_t model_out;              // Word stage1 should hold after the last access
    word_t written [num_words];    // Data of the full-word writes

    spram_top #(
        .write_mode   (tb_write_mode),
        .read_latency (tb_read_latency)
    ) dut0 (
        .clka   (clka),
        .rsta   (rsta),
        .req    (req),
        .regcea (regcea),
        .douta  (douta)
    );

    initial begin
        clka = 1'b0;
        forever #(clk_period / 2) clka = ~clka;
    end

    // Watchdog
    initial begin
        #(num_tests * cycle_budget * clk_period);
        $display("Run timed out after %0d cycles", num_tests * cycle_budget);
        fail_run();
    end

    task automatic fail_run();
        $display("** FAIL **");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            fail_run();
        end
    endtask

    // Every bit of an enabled byte lane set
    function automatic word_t lane_mask(be_t lanes);
        word_t mask;
        mask = '0;
        for (int b = 0; b < num_bytes; b++) begin
            mask[b*`SPRAM_BYTE_WIDTH +: `SPRAM_BYTE_WIDTH] = {`SPRAM_BYTE_WIDTH{lanes[b]}};
        end
        return mask;
    endfunction

    function automatic addr_t word_addr(int i);
        return addr_t'(i * 7 + 3);   // Spread over the array
    endfunction

    // One access cycle followed by idle; returns the word douta should show
    task automatic access(input be_t we, input addr_t addr, input word_t din,
                          output word_t expected);
        word_t mask;
        word_t old_word;
        mask     = lane_mask(we);
        old_word = model_mem[addr];
        @(posedge clka);
        req <= '{en: 1'b1, we: we, addr: addr, din: din};
        @(posedge clka);                              // Access taken here
        req <= '{en: 1'b0, we: '0, addr: '0, din: '0};
        case (tb_write_mode)
            wm_read_first:  model_out = old_word;
            wm_write_first: model_out = (old_word & ~mask) | (din & mask);
            default: begin
                if (we == '0) begin
                    model_out = old_word;             // no_change keeps output on writes
                end
            end
        endcase
        model_mem[addr] = (old_word & ~mask) | (din & mask);
        expected = model_out;
    endtask

    // Wait out the rest of the latency, compare away from the edge
    task automatic expect_douta(input word_t expected);
        repeat (tb_read_latency - 1) @(posedge clka);
        @(negedge clka);
        check_word("douta", douta, expected);
    endtask

    task automatic test_after_reset();
        word_t expected;
        access('0, 6'd5, '0, expected);
        expect_douta('0);
        access('0, 6'd63, '0, expected);
        expect_douta('0);
    endtask

    task automatic test_full_writes();
        word_t expected;
        for (int i = 0; i < num_words; i++) begin
            written[i] = $urandom;
            access('1, word_addr(i), written[i], expected);
            expect_douta(expected);
        end
        for (int i = 0; i < num_words; i++) begin
            access('0, word_addr(i), '0, expected);
            expect_douta(written[i]);
        end
    endtask

    task automatic test_partial_write();
        word_t expected;
        word_t base;
        word_t part;
        base = $urandom;
        part = $urandom;
        access('1, 6'd20, base, expected);
        access(4'b0101, 6'd20, part, expected);
        access('0, 6'd20, '0, expected);
        expect_douta((base & ~lane_mask(4'b0101)) | (part & lane_mask(4'b0101)));
        base = (base & ~lane_mask(4'b0101)) | (part & lane_mask(4'b0101));
        part = $urandom;
        access(4'b1000, 6'd20, part, expected);
        access('0, 6'd20, '0, expected);
        expect_douta((base & 32'h00ff_ffff) | (part & 32'hff00_0000));
    endtask

    task automatic test_write_mode();
        word_t old_word;
        word_t din;
        word_t want;
        word_t expected;
        old_word = $urandom;
        din      = $urandom;
        access('1, 6'd30, old_word, expected);
        access('0, 6'd5, '0, expected);     // Never written, leaves zero on the output
        expect_douta('0);
        access(4'b0110, 6'd30, din, expected);
        case (tb_write_mode)
            wm_read_first:  want = old_word;
            wm_write_first: want = (old_word & 32'hff00_00ff) | (din & 32'h00ff_ff00);
            default:        want = '0;   // Last read stays on the output
        endcase
        expect_douta(want);
    endtask

    task automatic test_output_hold();
        word_t held;
        word_t ignored;
        access('0, word_addr(0), '0, held);
        expect_douta(held);
        if (tb_read_latency > 1) begin
            @(posedge clka);
            regcea <= 1'b0;
            for (int i = 1; i < 5; i++) begin
                access('0, word_addr(i), '0, ignored);
            end
            repeat (tb_read_latency) @(posedge clka);
            @(negedge clka);
            check_word("douta", douta, held);
            @(posedge clka);
            regcea <= 1'b1;
        end
        access('0, word_addr(1), '0, held);
        expect_douta(held);
        repeat (6) @(posedge clka);   // en stays low
        @(negedge clka);
        check_word("douta", douta, held);
    endtask

    task automatic test_async_reset();
        word_t expected;
        @(posedge clka);
        rsta <= 1'b1;
        #(clk_period / 4);            // Still before the next clka edge
        check_word("douta", douta, `SPRAM_RESET_VALUE);
        model_out = `SPRAM_RESET_VALUE;
        repeat (3) @(posedge clka);
        rsta <= 1'b0;
        for (int i = 0; i < num_words; i++) begin
            access('0, word_addr(i), '0, expected);
            expect_douta(written[i]);
        end
    endtask

    initial begin
        void'($urandom(32'h30b4_930a));
        rsta     <= 1'b1;             // Seen as a rising edge by the output registers
        regcea    = 1'b1;
        req       = '0;
        model_out = `SPRAM_RESET_VALUE;
        for (int i = 0; i < depth; i++) begin
            model_mem[i] = '0;
        end
        repeat (4) @(posedge clka);
        @(negedge clka);
        check_word("douta", douta, `SPRAM_RESET_VALUE);
        @(posedge clka);
        rsta <= 1'b0;

        test_after_reset();
        test_full_writes();
        test_partial_write();
        test_write_mode();
        test_output_hold();
        test_async_reset();

        repeat (2) @(posedge clka);
        if (dut0.asrt0.failures != 0) begin
            $display("Concurrent assertions failed %0d times", dut0.asrt0.failures);
            fail_run();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== spram_top.f ====
+incdir+.
spram_cfg_pkg.sv
spram_bus_pkg.sv
spram_core.sv
spram_out_pipe.sv
spram_top.sv
spram_asserts.sv
spram_tb.sv

// ==== spram_top.sv ====
// Single-port RAM top level with byte-lane writes, selectable write mode
// and read latency 1 to 5. An access at edge N shows on douta after edge
// N+L-1 when regcea is high at that final edge.
`default_nettype none
`timescale 1ns/1ps

`include "spram_defines.svh"

module spram_top #(
    parameter spram_cfg_pkg::write_mode_e write_mode   = spram_cfg_pkg::wm_write_first,
    parameter int                         read_latency = `SPRAM_READ_LATENCY
) (
    input  logic                      clka,
    input  logic                      rsta,     // Async, output side only
    input  spram_bus_pkg::spram_req_t req,
    input  logic                      regcea,
    output spram_cfg_pkg::word_t      douta
);
    import spram_cfg_pkg::*;
    import spram_bus_pkg::*;

    word_t stage1;   // Core output register into the pipe

    spram_core #(
        .write_mode (write_mode)
    ) core0 (
        .clka   (clka),
        .rsta   (rsta),
        .req    (req),
        .stage1 (stage1)
    );

    spram_out_pipe #(
        .read_latency (read_latency)
    ) pipe0 (
        .clka   (clka),
        .rsta   (rsta),
        .stage1 (stage1),
        .regcea (regcea),
        .douta  (douta)
    );

endmodule

`default_nettype wire
